//--- verilog.f
+incdir+.
fb_pkg.sv
fb_ifs.sv
fb_sram.sv
fb_pipeline.sv
req_arbiter.sv
lane_gather.sv
fb_cluster.sv
tb_fb_cluster.sv

//--- Makefile
TOP = tb_fb_cluster

.PHONY: help test clean

help:
	@echo "targets: test clean help"

test:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- tb_fb_cluster.sv
`timescale 1ns/1ns
`include "fb_consts.svh"

module tb_fb_cluster;

	// preload, directed and random waves, for the watchdog budget
	localparam int WAVES = 512 + 9 + 300;
	localparam int TIMEOUT_NS = (WAVES * 12 + 100) * 20;

	logic clk;
	logic nRST;
	logic [3:0] lane_valid;
	logic [127:0] lane_addr;
	logic [127:0] lane_wdata;
	logic [15:0] lane_wstrb;
	wire [3:0] lane_ready;
	wire [127:0] lane_rdata;

	// reference frame buffer
	logic [31:0] model [`FB_DEPTH];
	// expectation for the wave in flight
	logic [3:0] exp_mask;
	logic [127:0] exp_data;
	logic wave_open;
	string test_name;
	logic [31:0] seed;

	fb_cluster i_fb_cluster (
		.clk(clk),
		.nRST(nRST),
		.lane_valid(lane_valid),
		.lane_ready(lane_ready),
		.lane_addr(lane_addr),
		.lane_wdata(lane_wdata),
		.lane_wstrb(lane_wstrb),
		.lane_rdata(lane_rdata)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// preload pattern, every index bit shows up twice
	function automatic logic [31:0] fill_word(input int idx);
		return {idx[10:0], 5'h0b, ~idx[10:0], 5'h14};
	endfunction

	// one wave in ascending lane order, returns read data per lane
	function automatic logic [127:0] ref_wave(input logic [3:0] mask, input logic [127:0] addr,
		input logic [127:0] wdata, input logic [15:0] strb);
		logic [127:0] rd;
		logic [31:0] a;
		int idx;
		rd = '0;
		for (int i = 0; i < `FB_LANES; i++) begin
			a = addr[i*32 +: 32];
			// outside the window nothing happens, read data stays zero
			if (mask[i] && a >= `FB_BASE && a < `FB_LIMIT) begin
				idx = int'((a - `FB_BASE) >> 2);
				if (strb[i*4 +: 4] == 4'h0) begin
					rd[i*32 +: 32] = model[idx];
				end else begin
					for (int b = 0; b < 4; b++) begin
						if (strb[i*4 + b]) begin
							model[idx][b*8 +: 8] = wdata[i*32 + b*8 +: 8];
						end
					end
				end
			end
		end
		return rd;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] expv,
		input logic [31:0] act);
		if (act !== expv) begin
			$display("FAIL %s expected %08h actual %08h", name, expv, act);
			$display("Checks failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// called on a falling edge, returns on a falling edge after the idle cycle
	task automatic run_wave(input string name, input logic [3:0] mask, input logic [127:0] addr,
		input logic [127:0] wdata, input logic [15:0] strb);
		test_name = name;
		exp_mask = mask;
		exp_data = ref_wave(mask, addr, wdata, strb);
		lane_addr = addr;
		lane_wdata = wdata;
		lane_wstrb = strb;
		lane_valid = mask;
		wave_open = 1'b1;
		do begin
			@(negedge clk);
		end while (lane_ready == 4'h0);
		lane_valid = 4'h0;
		// gather sits idle one cycle
		@(negedge clk);
		wave_open = 1'b0;
	endtask

	// mask, addresses mostly in the window, mixed reads and writes
	task automatic make_random_wave(output logic [3:0] m, output logic [127:0] a,
		output logic [127:0] d, output logic [15:0] s);
		seed = lcg_next(seed);
		m = seed[19:16];
		if (m == 4'h0) begin
			m = 4'b1000;
		end
		for (int i = 0; i < 4; i++) begin
			seed = lcg_next(seed);
			s[i*4 +: 4] = seed[28] ? 4'h0 : seed[27:24];
			if (seed[31:30] != 2'b00) begin
				a[i*32 +: 32] = `FB_BASE + {19'h0, seed[12:0]};
			end else begin
				seed = lcg_next(seed);
				a[i*32 +: 32] = seed;
			end
			seed = lcg_next(seed);
			d[i*32 +: 32] = seed;
		end
	endtask

	// compare on every ready pulse, outputs settled since the rising edge
	always @(negedge clk) begin
		if (nRST && lane_ready != 4'h0) begin
			if (!wave_open) begin
				$display("lane_ready pulsed while no wave was in flight");
				$display("Checks failed");
				$fatal(1, "unexpected ready");
			end
			compare_word({test_name, " ready"}, {28'h0, exp_mask}, {28'h0, lane_ready});
			for (int i = 0; i < 4; i++) begin
				if (exp_mask[i]) begin
					compare_word($sformatf("%s lane%0d", test_name, i),
						exp_data[i*32 +: 32], lane_rdata[i*32 +: 32]);
				end
			end
		end
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout, a wave never saw lane_ready");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [3:0] m;
		logic [127:0] a;
		logic [127:0] d;
		logic [15:0] s;
		clk = 1'b0;
		nRST = 1'b0;
		lane_valid = 4'h0;
		lane_addr = '0;
		lane_wdata = '0;
		lane_wstrb = '0;
		wave_open = 1'b0;
		exp_mask = 4'h0;
		exp_data = '0;
		test_name = "reset";
		seed = 32'h2411_1cf9;
		repeat (4) @(posedge clk);
		@(negedge clk);
		nRST = 1'b1;

		// no valid, no ready
		repeat (5) begin
			@(negedge clk);
			compare_word("idle_after_reset", 32'h0, {28'h0, lane_ready});
		end

		// fill the whole frame buffer, four words per wave
		for (int w = 0; w < `FB_DEPTH / 4; w++) begin
			for (int i = 0; i < 4; i++) begin
				a[i*32 +: 32] = `FB_BASE + 32'((w * 4 + i) * 4);
				d[i*32 +: 32] = fill_word(w * 4 + i);
			end
			run_wave("preload", 4'hf, a, d, 16'hffff);
		end

		// single lane write then read back
		run_wave("single_write", 4'b0010, {64'h0, 32'h3010, 32'h0},
			{64'h0, 32'h1234_5678, 32'h0}, 16'h00f0);
		run_wave("single_read", 4'b0010, {64'h0, 32'h3010, 32'h0}, '0, 16'h0);

		// strobe 0101 merges bytes 0 and 2
		run_wave("full_write", 4'b0001, {96'h0, 32'h3100}, {96'h0, 32'h1122_3344}, 16'h000f);
		run_wave("partial_write", 4'b0001, {96'h0, 32'h3100}, {96'h0, 32'haabb_ccdd}, 16'h0005);
		run_wave("merge_read", 4'b0001, {96'h0, 32'h3100}, '0, 16'h0);

		// all four lanes, distinct words
		run_wave("four_lane_mixed", 4'hf, {32'h3300, 32'h4ffc, 32'h3204, 32'h3200},
			{32'h0, 32'h5a5a_0ff0, 32'h0, 32'hbeef_0001}, 16'h0f0f);
		run_wave("four_lane_readback", 4'hf, {32'h3300, 32'h4ffc, 32'h3204, 32'h3200},
			'0, 16'h0);

		// lane 2 reads what lane 0 wrote, 0x6000 is outside the window
		run_wave("same_word_and_window", 4'hf, {32'h6000, 32'h3400, 32'h6000, 32'h3400},
			{32'h0, 32'h0, 32'hdead_beef, 32'hcafe_f00d}, 16'h00ff);
		// 0x4000 is where a truncated 0x6000 would land
		run_wave("window_unchanged", 4'b0011, {64'h0, 32'h3000, 32'h4000}, '0, 16'h0);

		for (int n = 0; n < 300; n++) begin
			make_random_wave(m, a, d, s);
			run_wave($sformatf("random_%0d", n), m, a, d, s);
		end

		$display("All checks passed");
		$finish;
	end

endmodule

//--- fb_cluster.sv
`timescale 1ns/1ns
`include "fb_consts.svh"

module fb_cluster import fb_pkg::*; (
	input logic clk,
	input logic nRST,
	input lane_mask_t lane_valid,
	output lane_mask_t lane_ready,
	input logic [`FB_LANES*32-1:0] lane_addr,
	input logic [`FB_LANES*`FB_DATA_W-1:0] lane_wdata,
	input logic [`FB_LANES*`FB_STRB_W-1:0] lane_wstrb,
	output logic [`FB_LANES*`FB_DATA_W-1:0] lane_rdata
);

	// per-lane views of the flat ports
	logic [31:0] addr_w [`FB_LANES];
	fb_data_t wdata_w [`FB_LANES];
	fb_strb_t wstrb_w [`FB_LANES];
	fb_data_t rdata_w [`FB_LANES];
	// arbiter to pipeline
	logic stage_a_valid;
	fb_req_t stage_a;

	fb_req_if req_bus ();
	fb_resp_if resp_bus ();

	// lane i sits at slice i of each vector
	for (genvar i = 0; i < `FB_LANES; i++) begin : g_lane
		assign addr_w[i] = lane_addr[i*32 +: 32];
		assign wdata_w[i] = lane_wdata[i*`FB_DATA_W +: `FB_DATA_W];
		assign wstrb_w[i] = lane_wstrb[i*`FB_STRB_W +: `FB_STRB_W];
		assign lane_rdata[i*`FB_DATA_W +: `FB_DATA_W] = rdata_w[i];
	end

	lane_gather i_lane_gather (
		.clk(clk),
		.nRST(nRST),
		.lane_valid(lane_valid),
		.lane_addr(addr_w),
		.lane_wdata(wdata_w),
		.lane_wstrb(wstrb_w),
		.lane_ready(lane_ready),
		.lane_rdata(rdata_w),
		.req(req_bus.source),
		.resp(resp_bus.sink)
	);

	req_arbiter i_req_arbiter (
		.clk(clk),
		.nRST(nRST),
		.req(req_bus.arbiter),
		.stage_a_valid(stage_a_valid),
		.stage_a(stage_a)
	);

	fb_pipeline i_fb_pipeline (
		.clk(clk),
		.nRST(nRST),
		.stage_a_valid(stage_a_valid),
		.stage_a(stage_a),
		.resp(resp_bus.source)
	);

endmodule

//--- lane_gather.sv
`timescale 1ns/1ns
`include "fb_consts.svh"

module lane_gather import fb_pkg::*; (
	input logic clk,
	input logic nRST,
	input lane_mask_t lane_valid,
	input logic [31:0] lane_addr [`FB_LANES],
	input fb_data_t lane_wdata [`FB_LANES],
	input fb_strb_t lane_wstrb [`FB_LANES],
	output lane_mask_t lane_ready,
	output fb_data_t lane_rdata [`FB_LANES],
	fb_req_if.source req,
	fb_resp_if.sink resp
);

	lane_mask_t in_win;
	fb_addr_t word_idx [`FB_LANES];
	// wave bookkeeping
	logic busy;
	lane_mask_t cap_mask;
	lane_mask_t served;
	lane_mask_t resp_hit;
	lane_mask_t served_nxt;
	logic start;

	// the only window decode in the design
	always_comb begin
		for (int i = 0; i < `FB_LANES; i++) begin
			in_win[i] = (lane_addr[i] >= `FB_BASE) && (lane_addr[i] < `FB_LIMIT);
			// byte offset into the window turned into words
			word_idx[i] = fb_addr_t'((lane_addr[i] - `FB_BASE) >> 2);
		end
	end

	// lane finished by the response arriving this cycle
	assign resp_hit = resp.resp_valid ? (lane_mask_t'(1) << resp.resp_id) : '0;
	assign served_nxt = served | resp_hit;

	// capture only when idle and not in the ready cycle
	assign start = !busy && (lane_ready == '0) && (lane_valid != '0);

	always_ff @(posedge clk) begin
		if (!nRST) begin
			busy <= 1'b0;
			cap_mask <= '0;
			served <= '0;
			req.request <= '0;
			lane_ready <= '0;
		end else begin
			// ready is a single-cycle pulse
			lane_ready <= '0;
			if (start) begin
				busy <= 1'b1;
				cap_mask <= lane_valid;
				// out-of-window lanes are done already
				served <= lane_valid & ~in_win;
				req.request <= lane_valid & in_win;
			end else if (busy) begin
				// drop a request once the arbiter took it
				req.request <= req.request & ~req.grant;
				served <= served_nxt;
				if (served_nxt == cap_mask) begin
					busy <= 1'b0;
					lane_ready <= served_nxt;
				end
			end
		end
	end

	// request entries and read data buffer
	always_ff @(posedge clk) begin
		if (start) begin
			for (int i = 0; i < `FB_LANES; i++) begin
				req.req[i] <= '{
					addr: word_idx[i],
					wdata: lane_wdata[i],
					strb: lane_wstrb[i],
					id: lane_id_t'(i)
				};
				// outside the window reads back zero
				if (!in_win[i]) begin
					lane_rdata[i] <= '0;
				end
			end
		end
		if (resp.resp_valid) begin
			lane_rdata[resp.resp_id] <= resp.resp_data;
		end
	end

	// ready names only lanes of the wave whose requests all went to the arbiter
	a_ready_in_wave: assert property (@(posedge clk) disable iff (!nRST)
		(lane_ready & (~cap_mask | req.request)) == '0);

	// each requested lane gets exactly one response during its wave
	a_resp_expected: assert property (@(posedge clk) disable iff (!nRST)
		resp.resp_valid |-> busy && cap_mask[resp.resp_id] && !served[resp.resp_id]);

endmodule

//--- req_arbiter.sv
`timescale 1ns/1ns
`include "fb_consts.svh"

module req_arbiter import fb_pkg::*; (
	input logic clk,
	input logic nRST,
	fb_req_if.arbiter req,
	output logic stage_a_valid,
	output fb_req_t stage_a
);

	lane_id_t sel;
	logic found;

	// priority encoder where the lowest lane wins
	// walk down so the last hit is the lowest index
	always_comb begin
		sel = '0;
		found = 1'b0;
		for (int i = `FB_LANES - 1; i >= 0; i--) begin
			if (req.request[i]) begin
				sel = lane_id_t'(i);
				found = 1'b1;
			end
		end
		req.grant = found ? (lane_mask_t'(1) << sel) : '0;
	end

	// stage A valid
	always_ff @(posedge clk) begin
		if (!nRST) begin
			stage_a_valid <= 1'b0;
		end else begin
			stage_a_valid <= found;
		end
	end

	// stage A payload with the lane id taken from the entry
	always_ff @(posedge clk) begin
		if (found) begin
			stage_a <= req.req[sel];
		end
	end

	// grant is the lowest set request bit and thus one-hot or zero
	a_grant_lowest: assert property (@(posedge clk) disable iff (!nRST)
		req.grant == (req.request & lane_mask_t'(~req.request + 1'b1)));

endmodule

//--- fb_pipeline.sv
`timescale 1ns/1ns
`include "fb_consts.svh"

module fb_pipeline import fb_pkg::*; (
	input logic clk,
	input logic nRST,
	input logic stage_a_valid,
	input fb_req_t stage_a,
	fb_resp_if.source resp
);

	logic sram_wr;
	logic sram_rd;
	fb_data_t sram_rdata;
	// stage B, beside the sram read
	logic b_valid;
	logic b_rd;
	lane_id_t b_id;

	// stage A drives the memory, zero strobe means read
	assign sram_wr = stage_a_valid && (stage_a.strb != '0);
	assign sram_rd = stage_a_valid && (stage_a.strb == '0);

	fb_sram i_fb_sram (
		.clk(clk),
		.wr_en(sram_wr),
		.rd_en(sram_rd),
		.addr(stage_a.addr),
		.byte_en(stage_a.strb),
		.wdata(stage_a.wdata),
		.rdata(sram_rdata)
	);

	// valid chain A -> B -> C
	always_ff @(posedge clk) begin
		if (!nRST) begin
			b_valid <= 1'b0;
			resp.resp_valid <= 1'b0;
		end else begin
			b_valid <= stage_a_valid;
			resp.resp_valid <= b_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (stage_a_valid) begin
			b_id <= stage_a.id;
			b_rd <= sram_rd;
		end
		// stage C, writes answer with zero
		if (b_valid) begin
			resp.resp_id <= b_id;
			resp.resp_data <= b_rd ? sram_rdata : '0;
		end
	end

	// a lane has at most one access in flight
	a_ids_unique: assert property (@(posedge clk) disable iff (!nRST)
		!(stage_a_valid && b_valid && (stage_a.id == b_id)) &&
		!(stage_a_valid && resp.resp_valid && (stage_a.id == resp.resp_id)) &&
		!(b_valid && resp.resp_valid && (b_id == resp.resp_id)));

endmodule

//--- fb_sram.sv
`timescale 1ns/1ns
`include "fb_consts.svh"

module fb_sram import fb_pkg::*; (
	input logic clk,
	input logic wr_en,
	input logic rd_en,
	input fb_addr_t addr,
	input fb_strb_t byte_en,
	input fb_data_t wdata,
	output fb_data_t rdata
);

	// single port, one word per index
	fb_data_t mem [`FB_DEPTH];

	always_ff @(posedge clk) begin
		// only enabled bytes change
		if (wr_en) begin
			for (int b = 0; b < `FB_STRB_W; b++) begin
				if (byte_en[b]) begin
					mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
		// registered read, one cycle
		if (rd_en) begin
			rdata <= mem[addr];
		end
	end

endmodule

//--- fb_ifs.sv
`timescale 1ns/1ns
`include "fb_consts.svh"

// per-lane requests from gather to the arbiter
// request bit and entry stay put until grant is seen
interface fb_req_if import fb_pkg::*; ();
	lane_mask_t request;
	fb_req_t req [`FB_LANES];
	// combinational, one-hot or zero
	lane_mask_t grant;

	modport source (
		output request,
		output req,
		input grant
	);

	modport arbiter (
		input request,
		input req,
		output grant
	);
endinterface

// tagged responses from the pipeline, no back-pressure
interface fb_resp_if import fb_pkg::*; ();
	logic resp_valid;
	lane_id_t resp_id;
	fb_data_t resp_data;

	modport source (
		output resp_valid,
		output resp_id,
		output resp_data
	);

	modport sink (
		input resp_valid,
		input resp_id,
		input resp_data
	);
endinterface

//--- fb_pkg.sv
`include "fb_consts.svh"

package fb_pkg;

	// lane number inside a wave
	typedef logic [$clog2(`FB_LANES)-1:0] lane_id_t;
	// one bit per lane
	typedef logic [`FB_LANES-1:0] lane_mask_t;
	// word index into the frame buffer
	typedef logic [`FB_ADDR_W-1:0] fb_addr_t;
	typedef logic [`FB_DATA_W-1:0] fb_data_t;
	// all strobes low means a read
	typedef logic [`FB_STRB_W-1:0] fb_strb_t;

	// one frame buffer access, tagged with the lane it came from
	typedef struct packed {
		fb_addr_t addr;
		fb_data_t wdata;
		fb_strb_t strb;
		lane_id_t id;
	} fb_req_t;

endpackage

//--- fb_consts.svh
`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// lanes per wave, one per core
`define FB_LANES 4

// frame buffer size in 32-bit words
`define FB_DEPTH 2048
`define FB_ADDR_W 11

// data word and its byte strobes
`define FB_DATA_W 32
`define FB_STRB_W 4

// byte address window mapped onto the frame buffer
// upper bound is exclusive
`define FB_BASE 32'h0000_3000
`define FB_LIMIT 32'h0000_5000

`endif
